/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = histTb
FILELIST  = vlog.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Simulation failed
PASS_MSG  = Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "test FAILED"; exit 1; fi
	@echo "test PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/histPkg.sv */
`default_nettype none

package histPkg;

    // raw timestamp from the detector front end
    localparam int stampBits = 10;

    // low timestamp bits dropped by the quantizer
    localparam int binShift = 6;

    // bin index is whatever is left above binShift
    // 16 bins per pixel histogram
    localparam int binBits = stampBits - binShift;

    // 4 pixels share one count RAM
    localparam int pixelBits = 2;

    // RAM address is {pixel, bin}
    // 64 words in total
    localparam int addrBits = pixelBits + binBits;

    // width of one bin count
    localparam int countBits = 8;

    // counts stick here instead of wrapping
    localparam int countMax = (1 << countBits) - 1;

    // default address FIFO depth, must stay a power of two
    localparam int fifoDepth = 4;

endpackage

`default_nettype wire

/* design/addrFifo.sv */
`timescale 1ns/1ns
`default_nettype none

module addrFifo #(
    parameter int depth = histPkg::fifoDepth
) (
    input  wire                         clk,
    input  wire                         res,
    input  wire                         pushValid,
    input  wire  [histPkg::addrBits-1:0] pushAddr,
    input  wire                         pop,
    output logic [histPkg::addrBits-1:0] popAddr,
    output logic                        full,
    output logic                        empty
);
    import histPkg::*;

    localparam int ptrBits = $clog2(depth);

    logic [addrBits-1:0] mem [depth];
    logic [ptrBits-1:0] wrPtr;
    logic [ptrBits-1:0] rdPtr;
    // one extra bit so a full buffer is distinguishable
    logic [ptrBits:0] count;
    logic doPush;
    logic doPop;

    assign full = (count == (ptrBits + 1)'(depth));
    assign empty = (count == '0);

    // guard both sides so a bad neighbour cannot corrupt the pointers
    assign doPush = pushValid && !full;
    assign doPop = pop && !empty;

    // head shown directly, first word fall through
    assign popAddr = mem[rdPtr];

    // storage only, pointers carry the state
    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushAddr;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            // pointers wrap naturally, depth is a power of two
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

    // quantizer must respect full
    noOverflow: assert property (
        @(posedge clk) disable iff (!res) pushValid |-> !full
    ) else $error("addrFifo overflow");

    // builder must respect empty
    noUnderflow: assert property (
        @(posedge clk) disable iff (!res) pop |-> !empty
    ) else $error("addrFifo underflow");

endmodule

`default_nettype wire

/* design/binQuantizer.sv */
`timescale 1ns/1ns
`default_nettype none

module binQuantizer (
    input  wire                          clk,
    input  wire                          res,
    input  wire                          stampReq,
    input  wire  [histPkg::stampBits-1:0] stamp,
    input  wire  [histPkg::pixelBits-1:0] pixel,
    output logic                         stampAck,
    input  wire                          full,
    output logic                         pushValid,
    output logic [histPkg::addrBits-1:0]  pushAddr
);
    import histPkg::*;

    // two-phase view of the four-phase link
    typedef enum logic {
        qWait,
        qAcked
    } quantStateT;

    quantStateT state;
    logic accept;
    logic [binBits-1:0] binIdx;

    // top bits of the stamp select the bin
    assign binIdx = stamp[stampBits-1:binShift];

    // a full fifo holds the source off by keeping ack low
    assign accept = stampReq && !stampAck && !full;

    // push happens in the accept cycle itself
    assign pushValid = accept;
    assign pushAddr = {pixel, binIdx};

    // ack is the state bit, so it rises one edge after accept
    assign stampAck = (state == qAcked);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= qWait;
        end else begin
            case (state)
                qWait: begin
                    if (accept) begin
                        state <= qAcked;
                    end
                end
                qAcked: begin
                    // source released req so ack drops on this edge
                    if (!stampReq) begin
                        state <= qWait;
                    end
                end
                default: state <= qWait;
            endcase
        end
    end

    // a request raised under a high ack would be swallowed without a push
    reqAfterAck: assert property (
        @(posedge clk) disable iff (!res)
        $rose(stampReq) |-> !stampAck
    ) else $error("stampReq rose while stampAck was still high");

endmodule

`default_nettype wire

/* design/histTop.sv */
`timescale 1ns/1ns
`default_nettype none

module histTop (
    input  wire                          clk,
    input  wire                          res,
    input  wire                          stampReq,
    input  wire  [histPkg::stampBits-1:0] stamp,
    input  wire  [histPkg::pixelBits-1:0] pixel,
    output logic                         stampAck,
    input  wire                          readReq,
    input  wire  [histPkg::addrBits-1:0]  readAddr,
    output logic                         readAck,
    output logic [histPkg::countBits-1:0] readCount
);
    import histPkg::*;

    // quantizer to fifo
    logic pushValid;
    logic [addrBits-1:0] pushAddr;
    logic full;

    // fifo to builder
    logic empty;
    logic pop;
    logic [addrBits-1:0] popAddr;

    binQuantizer quant (
        .clk       (clk),
        .res       (res),
        .stampReq  (stampReq),
        .stamp     (stamp),
        .pixel     (pixel),
        .stampAck  (stampAck),
        .full      (full),
        .pushValid (pushValid),
        .pushAddr  (pushAddr)
    );

    addrFifo fifo (
        .clk       (clk),
        .res       (res),
        .pushValid (pushValid),
        .pushAddr  (pushAddr),
        .pop       (pop),
        .popAddr   (popAddr),
        .full      (full),
        .empty     (empty)
    );

    histBuilder builder (
        .clk       (clk),
        .res       (res),
        .empty     (empty),
        .popAddr   (popAddr),
        .pop       (pop),
        .readReq   (readReq),
        .readAddr  (readAddr),
        .readAck   (readAck),
        .readCount (readCount)
    );

endmodule

`default_nettype wire

/* histBuilder/histBuilder.sv */
`timescale 1ns/1ns
`default_nettype none

module histBuilder (
    input  wire                          clk,
    input  wire                          res,
    input  wire                          empty,
    input  wire  [histPkg::addrBits-1:0]  popAddr,
    output logic                         pop,
    input  wire                          readReq,
    input  wire  [histPkg::addrBits-1:0]  readAddr,
    output logic                         readAck,
    output logic [histPkg::countBits-1:0] readCount
);
    import histPkg::*;

    // host readout sequence
    typedef enum logic [1:0] {
        rdIdle,
        rdRead,
        rdAck,
        rdRelease
    } readStateT;

    readStateT readState;

    logic readGrant;
    logic pipeWr;
    logic clrWr;

    // stage 2 holds the address whose count comes back this cycle
    logic s2Valid;
    logic [addrBits-1:0] s2Addr;

    // forwarded count when stage 2 wrote the bin stage 1 just read
    logic fwdHit;
    logic [countBits-1:0] fwdData;

    logic [countBits-1:0] baseCount;
    logic [countBits-1:0] incCount;

    // RAM side
    logic ramWrEn;
    logic [addrBits-1:0] ramWrAddr;
    logic [countBits-1:0] ramWrData;
    logic ramRdEn;
    logic [addrBits-1:0] ramRdAddr;
    logic [countBits-1:0] ramRdData;

    // updates win and readout waits for a drained fifo and an empty pipe
    assign pop = !empty && (readState == rdIdle);
    assign readGrant = readReq && empty && !s2Valid && (readState == rdIdle);

    // stage 1 read or readout read but never both
    assign ramRdEn = pop || readGrant;
    assign ramRdAddr = readGrant ? readAddr : popAddr;

    // stale RAM word is replaced by the value written last cycle
    assign baseCount = fwdHit ? fwdData : ramRdData;
    // saturating increment
    assign incCount = (baseCount == countBits'(countMax)) ? baseCount : baseCount + 1'b1;

    // write sources
    assign pipeWr = s2Valid;
    assign clrWr = (readState == rdRead);

    assign ramWrEn = pipeWr || clrWr;
    assign ramWrAddr = clrWr ? readAddr : s2Addr;
    assign ramWrData = clrWr ? '0 : incCount;

    // ack follows the state directly
    assign readAck = (readState == rdAck);

    // update pipeline control
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s2Valid <= 1'b0;
            fwdHit <= 1'b0;
        end else begin
            s2Valid <= pop;
            fwdHit <= pop && s2Valid && (s2Addr == popAddr);
        end
    end

    // pipeline payload
    always_ff @(posedge clk) begin
        if (pop) begin
            s2Addr <= popAddr;
        end
        fwdData <= incCount;
    end

    // readout FSM
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            readState <= rdIdle;
        end else begin
            case (readState)
                rdIdle: begin
                    if (readGrant) begin
                        readState <= rdRead;
                    end
                end
                // data arrives and the bin is cleared on the edge ack rises
                rdRead: readState <= rdAck;
                rdAck: begin
                    if (!readReq) begin
                        readState <= rdRelease;
                    end
                end
                // ack is low again before idle
                rdRelease: readState <= rdIdle;
                default: readState <= rdIdle;
            endcase
        end
    end

    // count held for the whole ack phase
    always_ff @(posedge clk) begin
        if (clrWr) begin
            readCount <= ramRdData;
        end
    end

    histRam ram (
        .clk    (clk),
        .wrEn   (ramWrEn),
        .wrAddr (ramWrAddr),
        .wrData (ramWrData),
        .rdEn   (ramRdEn),
        .rdAddr (ramRdAddr),
        .rdData (ramRdData)
    );

    // readout only starts on a quiet pipe, so the two writers never meet
    oneWriter: assert property (
        @(posedge clk) disable iff (!res) !(pipeWr && clrWr)
    ) else $error("pipeline and readout write in the same cycle");

    // clear write in rdRead reuses readAddr, host must keep it while req is high
    addrHeld: assert property (
        @(posedge clk) disable iff (!res)
        readReq && $past(readReq) |-> $stable(readAddr)
    ) else $error("readAddr changed while readReq was high");

endmodule

`default_nettype wire

/* histBuilder/histRam.sv */
`timescale 1ns/1ns
`default_nettype none

module histRam (
    input  wire                          clk,
    input  wire                          wrEn,
    input  wire  [histPkg::addrBits-1:0]  wrAddr,
    input  wire  [histPkg::countBits-1:0] wrData,
    input  wire                          rdEn,
    input  wire  [histPkg::addrBits-1:0]  rdAddr,
    output logic [histPkg::countBits-1:0] rdData
);
    import histPkg::*;

    // one word per pixel and bin
    localparam int words = 1 << addrBits;

    logic [countBits-1:0] mem [words];

    // write port
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // registered read port, data one cycle after rdEn
    // same address as a write in that cycle gives the old word,
    // builder forwards around it
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

`default_nettype wire

/* tests/histChecker.sv */
`timescale 1ns/1ns
`default_nettype none

module histChecker (
    input  wire                          clk,
    input  wire                          res,
    input  wire                          clearing,
    input  wire                          stampAck,
    input  wire  [histPkg::stampBits-1:0] stamp,
    input  wire  [histPkg::pixelBits-1:0] pixel,
    input  wire                          readAck,
    input  wire  [histPkg::addrBits-1:0]  readAddr,
    input  wire  [histPkg::countBits-1:0] readCount,
    input  wire                          expUsed,
    input  wire  [histPkg::countBits-1:0] expCount,
    output int                           errors,
    output int                           readsChecked,
    output int                           stampsCounted
);
    import histPkg::*;

    // reference histogram, one entry per pixel and bin
    int model [1 << addrBits];
    logic ackSeen;
    logic readSeen;

    // bin is the stamp divided by 2**binShift, word is pixel times bins plus bin
    function automatic int wordOf(input int stampVal, input int pixelVal);
        int binIdx;
        binIdx = stampVal / (1 << binShift);
        return pixelVal * (1 << binBits) + binIdx;
    endfunction

    always @(posedge clk or negedge res) begin
        int w;
        if (!res) begin
            ackSeen <= 1'b0;
            readSeen <= 1'b0;
        end else begin
            ackSeen <= stampAck;
            readSeen <= readAck;
            // source still holds stamp and pixel when ack first shows
            if (stampAck && !ackSeen) begin
                w = wordOf(int'(stamp), int'(pixel));
                // counts stick at the top
                if (model[w] < countMax) begin
                    model[w] = model[w] + 1;
                end
                stampsCounted = stampsCounted + 1;
            end
            // rising readAck, count is valid and the bin is gone in the DUT
            if (readAck && !readSeen) begin
                if (!clearing) begin
                    readsChecked = readsChecked + 1;
                    if (readCount !== countBits'(model[readAddr])) begin
                        $display("Fail at %0t: bin %0d read %0d, model expects %0d",
                                 $time, readAddr, readCount, model[readAddr]);
                        errors = errors + 1;
                    end
                    if (expUsed && (readCount !== expCount)) begin
                        $display("Fail at %0t: bin %0d read %0d, table expects %0d",
                                 $time, readAddr, readCount, expCount);
                        errors = errors + 1;
                    end
                end
                model[readAddr] = 0;
            end
        end
    end

endmodule

`default_nettype wire

/* tests/histTb.sv */
`timescale 1ns/1ns
`default_nettype none

module histTb;
    import histPkg::*;

    localparam int resetCycles = 4;
    localparam int holdCycles = 40;
    localparam int words = 1 << addrBits;
    localparam logic [1:0] kStamp = 2'd0;
    localparam logic [1:0] kRead = 2'd1;
    // readout held open while stamps pile up behind it
    localparam logic [1:0] kBurst = 2'd2;

    typedef struct packed {
        logic [1:0] kind;
        logic [15:0] reps;
        logic [stampBits-1:0] stamp;
        logic [pixelBits-1:0] pixel;
        logic [addrBits-1:0] addr;
        logic [countBits-1:0] expCount;
    } entryT;

    logic clk;
    logic res;
    logic stampReq;
    logic [stampBits-1:0] stamp;
    logic [pixelBits-1:0] pixel;
    logic stampAck;
    logic readReq;
    logic [addrBits-1:0] readAddr;
    logic readAck;
    logic [countBits-1:0] readCount;
    logic clearing;
    logic expUsed;
    logic [countBits-1:0] expCount;
    int errors;
    int readsChecked;
    int stampsCounted;
    int otherErrors = 0;
    int readsIssued = 0;
    int cycles = 0;
    int limit;
    entryT stimTable [$];

    always #20 clk = ~clk;

    histTop uut (
        .clk       (clk),
        .res       (res),
        .stampReq  (stampReq),
        .stamp     (stamp),
        .pixel     (pixel),
        .stampAck  (stampAck),
        .readReq   (readReq),
        .readAddr  (readAddr),
        .readAck   (readAck),
        .readCount (readCount)
    );

    histChecker check (
        .clk           (clk),
        .res           (res),
        .clearing      (clearing),
        .stampAck      (stampAck),
        .stamp         (stamp),
        .pixel         (pixel),
        .readAck       (readAck),
        .readAddr      (readAddr),
        .readCount     (readCount),
        .expUsed       (expUsed),
        .expCount      (expCount),
        .errors        (errors),
        .readsChecked  (readsChecked),
        .stampsCounted (stampsCounted)
    );

    task automatic addEntry(input logic [1:0] kind, input int reps,
                            input logic [stampBits-1:0] s, input logic [pixelBits-1:0] p,
                            input logic [addrBits-1:0] a, input int exp);
        stimTable.push_back('{kind, 16'(reps), s, p, a, countBits'(exp)});
    endtask

    // keep the bin, scramble the bits below it
    function automatic logic [stampBits-1:0] randomLow(input logic [stampBits-1:0] s);
        return {s[stampBits-1:binShift], binShift'($urandom)};
    endfunction

    // full four-phase cycle on the stamp link, entered on a rising edge
    task automatic sendStamp(input logic [stampBits-1:0] s, input logic [pixelBits-1:0] p);
        stamp <= s;
        pixel <= p;
        stampReq <= 1'b1;
        @(posedge clk);
        while (!stampAck) @(posedge clk);
        stampReq <= 1'b0;
        @(posedge clk);
        while (stampAck) @(posedge clk);
    endtask

    // host readout, req held for hold extra cycles after ack
    task automatic readBin(input logic [addrBits-1:0] a, input logic [countBits-1:0] e,
                           input logic useExp, input int hold);
        readAddr <= a;
        expCount <= e;
        expUsed <= useExp;
        readReq <= 1'b1;
        if (useExp) begin
            readsIssued = readsIssued + 1;
        end
        @(posedge clk);
        while (!readAck) @(posedge clk);
        repeat (hold) @(posedge clk);
        readReq <= 1'b0;
        @(posedge clk);
        while (readAck) @(posedge clk);
    endtask

    // pops are stalled during the held readout, so the fifo fills and back-pressures
    task automatic runBurst(input entryT e);
        fork
            readBin(e.addr, e.expCount, 1'b1, holdCycles);
            begin
                @(posedge clk);
                while (!readAck) @(posedge clk);
                for (int r = 0; r < int'(e.reps); r++) begin
                    sendStamp(randomLow(e.stamp), e.pixel);
                end
            end
        join
    endtask

    task automatic buildTable();
        // one event per pixel, then untouched bins, then a repeated read
        addEntry(kStamp, 1, 10'h000, 2'd0, 6'h00, 0);
        addEntry(kStamp, 1, 10'h1c5, 2'd1, 6'h00, 0);
        addEntry(kStamp, 1, 10'h3ff, 2'd3, 6'h00, 0);
        addEntry(kStamp, 1, 10'h280, 2'd2, 6'h00, 0);
        addEntry(kRead, 1, 10'h000, 2'd0, 6'h00, 1);
        addEntry(kRead, 1, 10'h000, 2'd0, 6'h17, 1);
        addEntry(kRead, 1, 10'h000, 2'd0, 6'h3f, 1);
        addEntry(kRead, 1, 10'h000, 2'd0, 6'h2a, 1);
        addEntry(kRead, 1, 10'h000, 2'd0, 6'h01, 0);
        addEntry(kRead, 1, 10'h000, 2'd0, 6'h20, 0);
        addEntry(kRead, 1, 10'h000, 2'd0, 6'h00, 0);
        // same bin without gaps
        addEntry(kStamp, 20, 10'h0c0, 2'd1, 6'h00, 0);
        addEntry(kRead, 1, 10'h000, 2'd0, 6'h13, 20);
        // stamps differing below binShift
        addEntry(kStamp, 1, 10'h140, 2'd2, 6'h00, 0);
        addEntry(kStamp, 1, 10'h155, 2'd2, 6'h00, 0);
        addEntry(kStamp, 1, 10'h17f, 2'd2, 6'h00, 0);
        addEntry(kRead, 1, 10'h000, 2'd0, 6'h25, 3);
        // saturation
        addEntry(kStamp, 260, 10'h2c0, 2'd3, 6'h00, 0);
        addEntry(kRead, 1, 10'h000, 2'd0, 6'h3b, 255);
        addEntry(kRead, 1, 10'h000, 2'd0, 6'h3b, 0);
        // bursts longer than the fifo
        addEntry(kBurst, 12, 10'h380, 2'd0, 6'h3b, 0);
        addEntry(kRead, 1, 10'h000, 2'd0, 6'h0e, 12);
        addEntry(kBurst, 9, 10'h040, 2'd2, 6'h0e, 0);
        addEntry(kRead, 1, 10'h000, 2'd0, 6'h21, 9);
        addEntry(kRead, 1, 10'h000, 2'd0, 6'h21, 0);
    endtask

    // run limit from the table length plus the clear pass
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: run stopped after %0d cycles with the table unfinished", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        int ops;
        void'($urandom(72740));
        clk = 1'b0;
        res = 1'b0;
        stampReq = 1'b0;
        stamp = '0;
        pixel = '0;
        readReq = 1'b0;
        readAddr = '0;
        clearing = 1'b1;
        expUsed = 1'b0;
        expCount = '0;
        buildTable();
        ops = 0;
        limit = (words + resetCycles) * 20;
        foreach (stimTable[i]) begin
            ops = ops + int'(stimTable[i].reps) + 1;
            if (stimTable[i].kind == kBurst) begin
                limit = limit + holdCycles;
            end
        end
        limit = limit + ops * 20;
        repeat (resetCycles) @(posedge clk);
        res <= 1'b1;
        @(posedge clk);
        // RAM has no reset, read every word once
        for (int a = 0; a < words; a++) begin
            readBin(addrBits'(a), '0, 1'b0, 0);
        end
        clearing <= 1'b0;
        foreach (stimTable[i]) begin
            case (stimTable[i].kind)
                kStamp: begin
                    for (int r = 0; r < int'(stimTable[i].reps); r++) begin
                        if (int'(stimTable[i].reps) > 1) begin
                            sendStamp(randomLow(stimTable[i].stamp), stimTable[i].pixel);
                        end else begin
                            sendStamp(stimTable[i].stamp, stimTable[i].pixel);
                        end
                    end
                end
                kRead: readBin(stimTable[i].addr, stimTable[i].expCount, 1'b1, 0);
                default: runBurst(stimTable[i]);
            endcase
            repeat ($urandom % 3) @(posedge clk);
        end
        repeat (4) @(posedge clk);
        if (readsChecked != readsIssued) begin
            $display("Checker saw %0d readouts but %0d were issued", readsChecked, readsIssued);
            otherErrors = otherErrors + 1;
        end
        $display("Done: %0d value errors, %0d other errors, %0d readouts, %0d stamps",
                 errors, otherErrors, readsChecked, stampsCounted);
        if ((errors + otherErrors) == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
common/histPkg.sv
design/binQuantizer.sv
design/addrFifo.sv
histBuilder/histRam.sv
histBuilder/histBuilder.sv
design/histTop.sv
tests/histChecker.sv
tests/histTb.sv
